//--- design/mem_pkg.sv
package mem_pkg;

   // Bus widths
   localparam int ADDR_W = 12;             // Word address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Cache geometry
   localparam int OFFSET_W = 2;            // 4 words per line
   localparam int INDEX_W  = 4;            // 16 lines
   localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

   // Split view used for the cache lookup
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } mem_addr_split_t;

   // One address word, read flat or split
   typedef union packed {
      logic [ADDR_W-1:0] flat;
      mem_addr_split_t   split;
   } mem_addr_u;

   // Request, wstrb of zero is a read
   typedef struct packed {
      logic              valid;
      mem_addr_u         addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } mem_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;     // One pulse per accepted read
      logic              ready;      // Acceptance of the request
   } mem_resp_t;

endpackage

//--- design/l1_cache.sv
`timescale 1ns/1ps

module l1_cache import mem_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      invalidate_i,
   input  mem_req_t  fe_req_i,
   output mem_resp_t fe_resp_o,
   output mem_req_t  be_req_o,
   input  mem_resp_t be_resp_i
);

   localparam int N_LINES = 2**INDEX_W;
   localparam int N_WORDS = 2**OFFSET_W;

   typedef enum logic [1:0] {S_IDLE, S_REFILL, S_WRITE} state_t;

   state_t              state;
   logic [TAG_W-1:0]    tag_mem  [N_LINES];
   logic [DATA_W-1:0]   data_mem [N_LINES][N_WORDS];
   logic [N_LINES-1:0]  line_valid;
   logic                inv_pend;      // Invalidate waiting for an idle cycle
   logic [OFFSET_W-1:0] refill_cnt;    // Next word of the line
   logic                rd_wait;       // Word requested, data not back yet
   logic [DATA_W-1:0]   rdata_q;
   logic                rvalid_q;

   mem_addr_u           addr;
   mem_addr_u           line_base;
   mem_addr_u           refill_addr;
   logic                is_read;
   logic                hit;
   logic                idle_free;
   logic                hit_read;
   logic                be_accept;
   logic                refill_done;

   assign addr      = fe_req_i.addr;
   assign is_read   = (fe_req_i.wstrb == '0);
   assign hit       = line_valid[addr.split.index] &&
                      (tag_mem[addr.split.index] == addr.split.tag);
   assign idle_free = (state == S_IDLE) && !inv_pend;   // No invalidation to apply
   assign hit_read  = idle_free && fe_req_i.valid && is_read && hit;

   // Refill walks the line from its first word
   always_comb begin
      line_base              = addr;
      line_base.split.offset = '0;
      refill_addr.flat       = line_base.flat + ADDR_W'(refill_cnt);
   end

   always_comb begin
      be_req_o       = fe_req_i;       // Write-through reuses the front-end fields
      be_req_o.valid = 1'b0;
      if (state == S_WRITE) begin
         be_req_o.valid = fe_req_i.valid;
      end else if (state == S_REFILL) begin
         be_req_o.valid = !rd_wait;
         be_req_o.addr  = refill_addr;
         be_req_o.wdata = '0;
         be_req_o.wstrb = '0;
      end
   end

   assign be_accept   = be_req_o.valid && be_resp_i.ready;
   assign refill_done = (state == S_REFILL) && be_resp_i.rvalid && (refill_cnt == '1);

   assign fe_resp_o.ready  = hit_read || ((state == S_WRITE) && be_accept);
   assign fe_resp_o.rvalid = rvalid_q;
   assign fe_resp_o.rdata  = rdata_q;

   // Arrays and read data
   always_ff @(posedge clk_i) begin
      if (hit_read) begin
         rdata_q <= data_mem[addr.split.index][addr.split.offset];
      end
      if ((state == S_REFILL) && be_resp_i.rvalid) begin
         data_mem[addr.split.index][refill_cnt] <= be_resp_i.rdata;
      end
      if (refill_done) begin
         tag_mem[addr.split.index] <= addr.split.tag;
      end
      // Keep a cached copy in step with the write-through
      if ((state == S_WRITE) && be_accept && hit) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (fe_req_i.wstrb[b]) begin
               data_mem[addr.split.index][addr.split.offset][8*b +: 8] <=
                  fe_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state      <= S_IDLE;
         line_valid <= '0;
         inv_pend   <= 1'b0;
         refill_cnt <= '0;
         rd_wait    <= 1'b0;
         rvalid_q   <= 1'b0;
      end else begin
         rvalid_q <= hit_read;            // Hit data one cycle after acceptance

         if (invalidate_i) begin
            inv_pend <= 1'b1;
         end else if (state == S_IDLE) begin
            inv_pend <= 1'b0;
         end

         case (state)
            S_IDLE: begin
               if (inv_pend) begin
                  line_valid <= '0;       // Request waits one cycle
               end else if (fe_req_i.valid && !is_read) begin
                  state <= S_WRITE;
               end else if (fe_req_i.valid && !hit) begin
                  state <= S_REFILL;
               end
            end
            S_REFILL: begin
               if (be_accept) begin
                  rd_wait <= 1'b1;
               end
               if (be_resp_i.rvalid) begin
                  rd_wait    <= 1'b0;
                  refill_cnt <= refill_cnt + 1'b1;   // Wraps to 0 at line end
               end
               if (refill_done) begin
                  line_valid[addr.split.index] <= 1'b1;
                  state <= S_IDLE;        // Lookup now hits
               end
            end
            S_WRITE: begin
               if (be_accept) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- design/bus_merge.sv
`timescale 1ns/1ps

module bus_merge import mem_pkg::*; #(
   parameter int N_PORTS = 2
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  m_req_i  [N_PORTS],
   output mem_resp_t m_resp_o [N_PORTS],
   output mem_req_t  s_req_o,
   input  mem_resp_t s_resp_i
);

   localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

   logic [IDX_W-1:0] gnt_q;      // Last granted master
   logic             locked;     // Read in flight
   logic             bus_idle;
   logic [IDX_W-1:0] pick;
   logic [IDX_W-1:0] sel;
   logic             accept;
   logic             found;
   int               cand;

   // Free again in the cycle of the read data
   assign bus_idle = !locked || s_resp_i.rvalid;

   // Round-robin search starting after the last grant
   always_comb begin
      pick  = gnt_q;
      found = 1'b0;
      cand  = 0;
      for (int k = 1; k <= N_PORTS; k++) begin
         cand = (int'(gnt_q) + k) % N_PORTS;
         if (!found && m_req_i[cand].valid) begin
            pick  = IDX_W'(cand);
            found = 1'b1;
         end
      end
   end

   assign sel     = bus_idle ? pick : gnt_q;
   assign s_req_o = m_req_i[sel];
   assign accept  = s_req_o.valid && s_resp_i.ready;

   // Only the selected master sees ready, only the owner sees data
   always_comb begin
      for (int p = 0; p < N_PORTS; p++) begin
         m_resp_o[p].ready  = s_resp_i.ready && m_req_i[p].valid && (sel == IDX_W'(p));
         m_resp_o[p].rvalid = s_resp_i.rvalid && locked && (gnt_q == IDX_W'(p));
         m_resp_o[p].rdata  = (gnt_q == IDX_W'(p)) ? s_resp_i.rdata : '0;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         gnt_q  <= IDX_W'(N_PORTS - 1);  // First search starts at port 0
         locked <= 1'b0;
      end else begin
         if (s_resp_i.rvalid) begin
            locked <= 1'b0;
         end
         if (accept) begin
            gnt_q <= sel;
            if (s_req_o.wstrb == '0) begin
               locked <= 1'b1;            // Hold grant until rvalid
            end
         end
      end
   end

endmodule

//--- design/ext_mem_ram.sv
`timescale 1ns/1ps

module ext_mem_ram import mem_pkg::*; #(
   parameter int RD_LATENCY = 3
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  mem_req_t  req_i,
   output mem_resp_t resp_o
);

   localparam int CNT_W = $clog2(RD_LATENCY + 1);

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic [CNT_W-1:0]  lat_cnt;     // Cycles left on the pending read
   logic [ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;
   logic              idle;
   logic              accept;
   logic              rd_last;

   assign idle    = (lat_cnt == '0);
   assign accept  = req_i.valid && idle;
   assign rd_last = (lat_cnt == CNT_W'(1));

   // Word a holds a
   initial begin
      for (int a = 0; a < 2**ADDR_W; a++) begin
         mem[a] = DATA_W'(a);
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && (req_i.wstrb != '0)) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               mem[req_i.addr.flat][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
      if (accept && (req_i.wstrb == '0)) begin
         rd_addr <= req_i.addr.flat;
      end
      if (rd_last) begin
         rdata_q <= mem[rd_addr];  // No write can land while a read waits
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lat_cnt  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_last;
         if (accept && (req_i.wstrb == '0)) begin
            lat_cnt <= CNT_W'(RD_LATENCY);
         end else if (!idle) begin
            lat_cnt <= lat_cnt - 1'b1;
         end
      end
   end

   assign resp_o.ready  = idle;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

//--- design/ext_mem_subsys.sv
`timescale 1ns/1ps

module ext_mem_subsys import mem_pkg::*; #(
   parameter int N_PORTS    = 2,
   parameter int RD_LATENCY = 3
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      invalidate_i,
   input  mem_req_t  req_i  [N_PORTS],
   output mem_resp_t resp_o [N_PORTS]
);

   mem_req_t  be_req  [N_PORTS];   // Cache back ends
   mem_resp_t be_resp [N_PORTS];
   mem_req_t  mem_req;
   mem_resp_t mem_resp;

   // Port 0 instructions, others data
   for (genvar g = 0; g < N_PORTS; g++) begin : g_cache
      l1_cache u_cache (
         .clk_i        (clk_i),
         .arst_i       (arst_i),
         .invalidate_i (invalidate_i),
         .fe_req_i     (req_i[g]),
         .fe_resp_o    (resp_o[g]),
         .be_req_o     (be_req[g]),
         .be_resp_i    (be_resp[g])
      );
   end

   bus_merge #(
      .N_PORTS (N_PORTS)
   ) u_merge (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .m_req_i  (be_req),
      .m_resp_o (be_resp),
      .s_req_o  (mem_req),
      .s_resp_i (mem_resp)
   );

   ext_mem_ram #(
      .RD_LATENCY (RD_LATENCY)
   ) u_ram (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .req_i  (mem_req),
      .resp_o (mem_resp)
   );

endmodule

//--- test/mem_checker.sv
`timescale 1ns/1ps

module mem_checker import mem_pkg::*; #(
   parameter int N_PORTS = 2
) (
   input logic      clk_i,
   input logic      arst_i,
   input mem_req_t  m_req_i  [N_PORTS],
   input mem_resp_t m_resp_i [N_PORTS],
   input mem_req_t  s_req_i,
   input mem_resp_t s_resp_i
);

   logic [N_PORTS-1:0] rdy_vec;
   logic               rd_out;     // Read accepted by the ram and not yet answered

   always_comb begin
      for (int p = 0; p < N_PORTS; p++) begin
         rdy_vec[p] = m_resp_i[p].ready;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_out <= 1'b0;
      end else if (s_req_i.valid && s_resp_i.ready && (s_req_i.wstrb == '0)) begin
         rd_out <= 1'b1;
      end else if (s_resp_i.rvalid) begin
         rd_out <= 1'b0;
      end
   end

   // One transaction on the ram at a time
   a_no_ready_busy: assert property (@(posedge clk_i) disable iff (arst_i)
      (rd_out && !s_resp_i.rvalid) |-> (rdy_vec == '0))
      else $error("a cache sees ready while a ram read is outstanding");

   a_rvalid_owed: assert property (@(posedge clk_i) disable iff (arst_i)
      s_resp_i.rvalid |-> rd_out)
      else $error("ram read data with no read outstanding");

   for (genvar g = 0; g < N_PORTS; g++) begin : g_hold
      a_hold: assert property (@(posedge clk_i) disable iff (arst_i)
         m_req_i[g].valid && !m_resp_i[g].ready |=> m_req_i[g].valid && $stable(m_req_i[g]))
         else $error("cache %0d dropped or changed a waiting request", g);
   end

endmodule

bind bus_merge mem_checker #(
   .N_PORTS (N_PORTS)
) u_checker (
   .clk_i    (clk_i),
   .arst_i   (arst_i),
   .m_req_i  (m_req_i),
   .m_resp_i (m_resp_o),
   .s_req_i  (s_req_o),
   .s_resp_i (s_resp_i)
);

//--- test/tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor import mem_pkg::*; #(
   parameter int N_PORTS = 2
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      invalidate_i,
   input  mem_req_t  req_i  [N_PORTS],
   input  mem_resp_t resp_i [N_PORTS],
   output int        mismatch_cnt_o,
   output int        error_cnt_o,
   output int        read_cnt_o,
   output int        write_cnt_o
);

   logic [DATA_W-1:0] ref_mem  [2**ADDR_W];   // Expected external memory
   logic              pend     [N_PORTS];     // Read accepted last cycle
   logic [DATA_W-1:0] exp_data [N_PORTS];
   logic [ADDR_W-1:0] exp_addr [N_PORTS];
   logic [ADDR_W-1:0] last_rd  [N_PORTS];
   logic              last_ok  [N_PORTS];     // Line of last_rd must still be cached
   int                wait_cnt [N_PORTS];

   function automatic logic [DATA_W-1:0] apply_strobe(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      for (int b = 0; b < STRB_W; b++) begin
         mask[8*b +: 8] = {8{strb[b]}};
      end
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   always @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         for (int a = 0; a < 2**ADDR_W; a++) begin
            ref_mem[a] = DATA_W'(a);
         end
         for (int p = 0; p < N_PORTS; p++) begin
            pend[p]     = 1'b0;
            last_ok[p]  = 1'b0;
            wait_cnt[p] = 0;
         end
         mismatch_cnt_o = 0;
         error_cnt_o    = 0;
         read_cnt_o     = 0;
         write_cnt_o    = 0;
      end else begin
         for (int p = 0; p < N_PORTS; p++) begin
            if (invalidate_i) begin
               last_ok[p] = 1'b0;
            end
            if (resp_i[p].ready && !req_i[p].valid) begin
               error_cnt_o++;
               $display("ERROR at %0t: port %0d raised ready with no request", $time, p);
            end
            // Response side first, a new request may start in the rvalid cycle
            if (resp_i[p].rvalid) begin
               if (!pend[p]) begin
                  error_cnt_o++;
                  $display("ERROR at %0t: port %0d gave read data with no read waiting",
                           $time, p);
               end else begin
                  read_cnt_o++;
                  if (resp_i[p].rdata !== exp_data[p]) begin
                     mismatch_cnt_o++;
                     $display("MISMATCH at %0t: port %0d read of %03h gave %08h, expected %08h",
                              $time, p, exp_addr[p], resp_i[p].rdata, exp_data[p]);
                  end
               end
               pend[p] = 1'b0;
            end else if (pend[p]) begin
               error_cnt_o++;
               $display("ERROR at %0t: port %0d read data did not follow acceptance by one cycle",
                        $time, p);
               pend[p] = 1'b0;
            end
            if (req_i[p].valid && resp_i[p].ready) begin
               if (req_i[p].wstrb == '0) begin
                  if (last_ok[p] && (last_rd[p] == req_i[p].addr.flat) && (wait_cnt[p] != 0)) begin
                     error_cnt_o++;
                     $display("ERROR at %0t: port %0d repeated read of %03h waited %0d cycles, no hit",
                              $time, p, req_i[p].addr.flat, wait_cnt[p]);
                  end
                  exp_data[p] = ref_mem[req_i[p].addr.flat];
                  exp_addr[p] = req_i[p].addr.flat;
                  pend[p]     = 1'b1;
                  last_rd[p]  = req_i[p].addr.flat;
                  last_ok[p]  = 1'b1;
               end else begin
                  ref_mem[req_i[p].addr.flat] = apply_strobe(ref_mem[req_i[p].addr.flat],
                                                             req_i[p].wdata, req_i[p].wstrb);
                  write_cnt_o++;
               end
               wait_cnt[p] = 0;
            end else if (req_i[p].valid) begin
               wait_cnt[p]++;                  // Back-pressure or refill
            end
         end
      end
   end

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top import mem_pkg::*; ();

   localparam int          N_PORTS    = 2;
   localparam int          N_TXN      = 400;          // Random requests per port
   localparam int          N_CROSS    = 8;            // Words shared in the cross phase
   localparam int          MAX_CYCLES = N_TXN * N_PORTS * 40;
   localparam logic [31:0] SEED       = 32'h79f3dc90;

   logic              clk_i;
   logic              arst_i;
   logic              invalidate_i;
   mem_req_t          req  [N_PORTS];
   mem_resp_t         resp [N_PORTS];
   logic [31:0]       rng  [N_PORTS];    // One generator state per port
   logic [ADDR_W-1:0] cross_addr [N_CROSS];
   int                cycle_cnt = 0;
   int                mismatch_cnt;
   int                error_cnt;
   int                read_cnt;
   int                write_cnt;

   ext_mem_subsys #(
      .N_PORTS    (N_PORTS),
      .RD_LATENCY (3)
   ) UUT (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .invalidate_i (invalidate_i),
      .req_i        (req),
      .resp_o       (resp)
   );

   tb_monitor #(
      .N_PORTS (N_PORTS)
   ) u_monitor (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .invalidate_i   (invalidate_i),
      .req_i          (req),
      .resp_i         (resp),
      .mismatch_cnt_o (mismatch_cnt),
      .error_cnt_o    (error_cnt),
      .read_cnt_o     (read_cnt),
      .write_cnt_o    (write_cnt)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand(input int p);
      rng[p] = lcg_step(rng[p]);
      return rng[p];
   endfunction

   // One request on port p, returns after ready (write) or rvalid (read)
   task automatic run_txn(input int p, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
      mem_req_t r;
      r.valid     = 1'b1;
      r.addr.flat = a;
      r.wdata     = d;
      r.wstrb     = s;
      req[p] <= r;
      @(posedge clk_i);
      while (!resp[p].ready) @(posedge clk_i);
      req[p] <= '0;
      if (s == '0) begin
         @(posedge clk_i);
         while (!resp[p].rvalid) @(posedge clk_i);
      end
   endtask

   task automatic random_traffic(input int p);
      logic [31:0]       r;
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] prev;
      logic [STRB_W-1:0] s;
      prev = {p[0], 11'h000};
      for (int i = 0; i < N_TXN; i++) begin
         r = next_rand(p);
         a = (r[6:5] == 2'b11) ? prev : {p[0], 3'b000, r[15:8]};  // Repeats give hits
         s = (r[2:1] == 2'b00) ? r[31:28] : '0;                   // A quarter are writes
         if ((r[2:1] == 2'b00) && (s == '0)) begin
            s = '1;
         end
         run_txn(p, a, next_rand(p), s);
         prev = a;
      end
   endtask

   // Port 1 writes behind port 0's cache, then an invalidate
   task automatic cross_phase();
      logic [31:0] r0;
      logic [31:0] r1;
      for (int k = 0; k < N_CROSS; k++) begin
         r0 = next_rand(0);
         cross_addr[k] = {1'b0, 3'b000, r0[15:8]};
         run_txn(0, cross_addr[k], '0, '0);
      end
      for (int k = 0; k < N_CROSS; k++) begin
         r1 = next_rand(1);
         run_txn(1, cross_addr[k], next_rand(1), (r1[31:28] == '0) ? '1 : r1[31:28]);
      end
      invalidate_i <= 1'b1;
      @(posedge clk_i);
      invalidate_i <= 1'b0;
      fork
         begin
            for (int k = 0; k < N_CROSS; k++) begin
               r0 = next_rand(0);
               run_txn(0, cross_addr[k], '0, '0);
               run_txn(0, {1'b1, 3'b000, r0[15:8]}, '0, '0);   // Other region
            end
         end
         begin
            for (int k = 0; k < N_CROSS; k++) begin
               run_txn(1, cross_addr[N_CROSS-1-k], '0, '0);
            end
         end
      join
   endtask

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("ERROR: run stopped after %0d cycles, a request never completed",
                  cycle_cnt);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial begin
      arst_i       = 1'b1;
      invalidate_i = 1'b0;
      for (int p = 0; p < N_PORTS; p++) begin
         req[p] = '0;
         rng[p] = SEED ^ (32'h9e3779b9 * p);
      end
      repeat (4) @(posedge clk_i);
      arst_i <= 1'b0;
      repeat (3) @(posedge clk_i);   // Quiet bus after reset
      fork
         random_traffic(0);
         random_traffic(1);
      join
      cross_phase();
      repeat (2) @(posedge clk_i);
      $display("Errors: %0d mismatches, %0d other; %0d reads and %0d writes seen",
               mismatch_cnt, error_cnt, read_cnt, write_cnt);
      if ((mismatch_cnt == 0) && (error_cnt == 0)) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- sim.f
design/mem_pkg.sv
design/l1_cache.sv
design/bus_merge.sv
design/ext_mem_ram.sv
design/ext_mem_subsys.sv
test/mem_checker.sv
test/tb_monitor.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_top --Mdir "$OBJ"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi
